// File: src/tag_pkg.sv
// ##########################################################
// shared types and default sizes for the tag tracker
// tags are not part of any struct since their width follows
// the num_tags_p parameter of each module
// the opcode is carried through the design but never decoded
// ##########################################################

`default_nettype none

package tag_pkg;

  // request opcode, 2 bits
  typedef enum logic [1:0] {
    op_read   = 2'd0,
    op_write  = 2'd1,
    op_atomic = 2'd2,
    op_flush  = 2'd3
  } tag_op_e;

  localparam int payload_width   = 24;
  localparam int resp_data_width = 16;

  // default pool depth, overridden from the top level
  localparam int default_num_tags = 8;

  // request as seen at the input, 26 bits
  typedef struct packed {
    tag_op_e                  op;
    logic [payload_width-1:0] addr;
  } req_payload_t;

  // outgoing issue, the tag travels next to it
  typedef struct packed {
    req_payload_t payload;
  } issue_t;

  // stored request joined with the response data, 42 bits
  typedef struct packed {
    req_payload_t               payload;
    logic [resp_data_width-1:0] data;
  } done_t;

endpackage

`default_nettype wire

// File: src/id_pool.sv
// ##########################################################
// free-tag pool with one allocated bit per tag
// always offers the lowest tag that is free or being freed
// in the current cycle, so a returned tag can go out again
// right away; a claim and a free of one tag in the same
// cycle leaves the tag allocated
// alloc_yumi_i must only be raised while alloc_v_o is high
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module id_pool #(
  parameter int num_tags_p = tag_pkg::default_num_tags,
  localparam int tag_width_lp = (num_tags_p > 1) ? $clog2(num_tags_p) : 1
) (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,

  // lowest available tag
  output logic [tag_width_lp-1:0]      alloc_id_o,
  output logic                         alloc_v_o,
  input  wire logic                    alloc_yumi_i,

  // tag coming back from a response
  input  wire logic                    dealloc_v_i,
  input  wire logic [tag_width_lp-1:0] dealloc_id_i
);

  logic [num_tags_p-1:0] allocated_r;
  logic [num_tags_p-1:0] dealloc_decode;
  logic [num_tags_p-1:0] alloc_decode;
  logic [num_tags_p-1:0] candidates;

  always_comb begin
    for (int i = 0; i < num_tags_p; i++) begin
      dealloc_decode[i] = dealloc_v_i && (dealloc_id_i == tag_width_lp'(i));
    end
  end

  // tags freed this cycle count as free already
  assign candidates = ~allocated_r | dealloc_decode;
  assign alloc_v_o  = |candidates;

  // scan from the top down so the lowest hit is kept
  always_comb begin
    alloc_id_o = '0;
    for (int i = num_tags_p - 1; i >= 0; i--) begin
      if (candidates[i]) begin
        alloc_id_o = tag_width_lp'(i);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < num_tags_p; i++) begin
      alloc_decode[i] = alloc_yumi_i && (alloc_id_o == tag_width_lp'(i));
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      allocated_r <= '0;
    end else begin
      for (int i = 0; i < num_tags_p; i++) begin
        // claim wins over a same-cycle free
        if (alloc_decode[i]) begin
          allocated_r[i] <= 1'b1;
        end else if (dealloc_decode[i]) begin
          allocated_r[i] <= 1'b0;
        end
      end
    end
  end

  // issuer may only take a tag that is on offer
  a_yumi_with_offer: assert property (@(posedge clk_i) disable iff (reset_i)
    alloc_yumi_i |-> alloc_v_o);

  // responses may only name a tag that went out earlier
  a_free_allocated: assert property (@(posedge clk_i) disable iff (reset_i)
    dealloc_v_i |-> |(dealloc_decode & allocated_r));

  a_free_in_range: assert property (@(posedge clk_i) disable iff (reset_i)
    dealloc_v_i |-> (int'(dealloc_id_i) < num_tags_p));

endmodule

`default_nettype wire

// File: src/request_issuer.sv
// ##########################################################
// request acceptance and tagging
// req_i must be held with req_v_i until req_yumi_o is seen
// the payload is written to the store under the claimed tag
// and the tagged issue is presented one cycle after accept
// no back-pressure on the issue output
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module request_issuer #(
  parameter int num_tags_p = tag_pkg::default_num_tags,
  localparam int tag_width_lp = (num_tags_p > 1) ? $clog2(num_tags_p) : 1
) (
  input  wire logic                    clk_i,
  input  wire logic                    reset_i,

  input  wire logic                    req_v_i,
  input  wire tag_pkg::req_payload_t   req_i,
  output logic                         req_yumi_o,

  // tag offer from the pool
  input  wire logic [tag_width_lp-1:0] alloc_id_i,
  input  wire logic                    alloc_v_i,
  output logic                         alloc_yumi_o,

  // store write port
  output logic                         st_we_o,
  output logic [tag_width_lp-1:0]      st_wtag_o,
  output tag_pkg::req_payload_t        st_wdata_o,

  output logic                         issue_v_o,
  output logic [tag_width_lp-1:0]      issue_tag_o,
  output tag_pkg::issue_t              issue_o
);

  logic accept;

  // take the request whenever a tag is on offer
  assign accept       = req_v_i & alloc_v_i;
  assign req_yumi_o   = accept;
  assign alloc_yumi_o = accept;

  assign st_we_o    = accept;
  assign st_wtag_o  = alloc_id_i;
  assign st_wdata_o = req_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      issue_v_o <= 1'b0;
    end else begin
      issue_v_o <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      issue_tag_o     <= alloc_id_i;
      issue_o.payload <= req_i;
    end
  end

  // every 2-bit code is an opcode, only unknown bits are illegal
  a_req_op_valid: assert property (@(posedge clk_i) disable iff (reset_i)
    req_v_i |-> !$isunknown(req_i.op));

endmodule

`default_nettype wire

// File: src/tag_store.sv
// ##########################################################
// payload store indexed by tag
// write at the clock edge, read is combinational
// a read and a write of one tag in the same cycle returns
// the old payload, the new one lands at the edge
// contents are undefined until a tag is first written
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module tag_store #(
  parameter int num_tags_p = tag_pkg::default_num_tags,
  localparam int tag_width_lp = (num_tags_p > 1) ? $clog2(num_tags_p) : 1
) (
  input  wire logic                    clk_i,

  // write side, from the issuer
  input  wire logic                    we_i,
  input  wire logic [tag_width_lp-1:0] wtag_i,
  input  wire tag_pkg::req_payload_t   wdata_i,

  // read side, from the completion unit
  input  wire logic [tag_width_lp-1:0] rtag_i,
  output tag_pkg::req_payload_t        rdata_o
);

  tag_pkg::req_payload_t mem [num_tags_p];

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[wtag_i] <= wdata_i;
    end
  end

  assign rdata_o = mem[rtag_i];

endmodule

`default_nettype wire

// File: src/completion_unit.sv
// ##########################################################
// response join and tag release
// resp_v_i is a single-cycle strobe naming an outstanding tag
// stored payload is read and the tag freed in that cycle,
// the joined result follows one cycle later
// results are not back-pressured
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module completion_unit #(
  parameter int num_tags_p = tag_pkg::default_num_tags,
  localparam int tag_width_lp = (num_tags_p > 1) ? $clog2(num_tags_p) : 1
) (
  input  wire logic                                  clk_i,
  input  wire logic                                  reset_i,

  input  wire logic                                  resp_v_i,
  input  wire logic [tag_width_lp-1:0]               resp_tag_i,
  input  wire logic [tag_pkg::resp_data_width-1:0]   resp_data_i,

  // store read port
  output logic [tag_width_lp-1:0]                    st_rtag_o,
  input  wire tag_pkg::req_payload_t                 st_rdata_i,

  // tag return to the pool
  output logic                                       dealloc_v_o,
  output logic [tag_width_lp-1:0]                    dealloc_id_o,

  output logic                                       done_v_o,
  output logic [tag_width_lp-1:0]                    done_tag_o,
  output tag_pkg::done_t                             done_o
);

  assign st_rtag_o    = resp_tag_i;
  assign dealloc_v_o  = resp_v_i;
  assign dealloc_id_o = resp_tag_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      done_v_o <= 1'b0;
    end else begin
      done_v_o <= resp_v_i;
    end
  end

  // payload captured before any same-cycle rewrite of the tag
  always_ff @(posedge clk_i) begin
    if (resp_v_i) begin
      done_tag_o     <= resp_tag_i;
      done_o.payload <= st_rdata_i;
      done_o.data    <= resp_data_i;
    end
  end

endmodule

`default_nettype wire

// File: src/tag_tracker_top.sv
// ##########################################################
// request-tag tracker for an out-of-order responder
// up to num_tags_p requests in flight, lowest free tag first
// request to issue and response to done are one cycle each
// no response ordering, timeouts or retry
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module tag_tracker_top #(
  parameter int num_tags_p = tag_pkg::default_num_tags,
  localparam int tag_width_lp = (num_tags_p > 1) ? $clog2(num_tags_p) : 1
) (
  input  wire logic                                clk_i,
  input  wire logic                                reset_i,

  input  wire logic                                req_v_i,
  input  wire tag_pkg::req_payload_t               req_i,
  output logic                                     req_yumi_o,

  output logic                                     issue_v_o,
  output logic [tag_width_lp-1:0]                  issue_tag_o,
  output tag_pkg::issue_t                          issue_o,

  input  wire logic                                resp_v_i,
  input  wire logic [tag_width_lp-1:0]             resp_tag_i,
  input  wire logic [tag_pkg::resp_data_width-1:0] resp_data_i,

  output logic                                     done_v_o,
  output logic [tag_width_lp-1:0]                  done_tag_o,
  output tag_pkg::done_t                           done_o
);

  logic [tag_width_lp-1:0] alloc_id;
  logic                    alloc_v;
  logic                    alloc_yumi;
  logic                    dealloc_v;
  logic [tag_width_lp-1:0] dealloc_id;

  logic                    st_we;
  logic [tag_width_lp-1:0] st_wtag;
  tag_pkg::req_payload_t   st_wdata;
  logic [tag_width_lp-1:0] st_rtag;
  tag_pkg::req_payload_t   st_rdata;

  id_pool #(.num_tags_p(num_tags_p)) u_id_pool (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .alloc_id_o  (alloc_id),
    .alloc_v_o   (alloc_v),
    .alloc_yumi_i(alloc_yumi),
    .dealloc_v_i (dealloc_v),
    .dealloc_id_i(dealloc_id)
  );

  request_issuer #(.num_tags_p(num_tags_p)) u_request_issuer (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .req_v_i     (req_v_i),
    .req_i       (req_i),
    .req_yumi_o  (req_yumi_o),
    .alloc_id_i  (alloc_id),
    .alloc_v_i   (alloc_v),
    .alloc_yumi_o(alloc_yumi),
    .st_we_o     (st_we),
    .st_wtag_o   (st_wtag),
    .st_wdata_o  (st_wdata),
    .issue_v_o   (issue_v_o),
    .issue_tag_o (issue_tag_o),
    .issue_o     (issue_o)
  );

  tag_store #(.num_tags_p(num_tags_p)) u_tag_store (
    .clk_i  (clk_i),
    .we_i   (st_we),
    .wtag_i (st_wtag),
    .wdata_i(st_wdata),
    .rtag_i (st_rtag),
    .rdata_o(st_rdata)
  );

  completion_unit #(.num_tags_p(num_tags_p)) u_completion_unit (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .resp_v_i    (resp_v_i),
    .resp_tag_i  (resp_tag_i),
    .resp_data_i (resp_data_i),
    .st_rtag_o   (st_rtag),
    .st_rdata_i  (st_rdata),
    .dealloc_v_o (dealloc_v),
    .dealloc_id_o(dealloc_id),
    .done_v_o    (done_v_o),
    .done_tag_o  (done_tag_o),
    .done_o      (done_o)
  );

endmodule

`default_nettype wire

// File: sim/tb_tag_tracker.sv
// ##########################################################
// random traffic testbench for tag_tracker_top with 8 tags
// a model here tracks outstanding tags and stored payloads
// responses only ever name tags the model holds outstanding
// 64-cycle phases of slow and fast responses fill the pool
// and drain it again, stimulus comes from a fixed-seed LFSR
// ##########################################################

`timescale 1ns/10ps
`default_nettype none

module tb_tag_tracker;

  localparam int num_tags_lp     = 8;
  localparam int tag_width_lp    = 3;
  localparam int num_cycles_lp   = 2000;
  localparam int reset_cycles_lp = 3;
  localparam int clk_period_lp   = 100;

  typedef struct packed {
    logic [tag_width_lp-1:0] tag;
    tag_pkg::req_payload_t   payload;
  } exp_issue_t;

  typedef struct packed {
    logic [tag_width_lp-1:0] tag;
    tag_pkg::done_t          result;
  } exp_done_t;

  logic                                clk_i;
  logic                                reset_i;
  logic                                req_v_i;
  tag_pkg::req_payload_t               req_i;
  logic                                req_yumi_o;
  logic                                issue_v_o;
  logic [tag_width_lp-1:0]             issue_tag_o;
  tag_pkg::issue_t                     issue_o;
  logic                                resp_v_i;
  logic [tag_width_lp-1:0]             resp_tag_i;
  logic [tag_pkg::resp_data_width-1:0] resp_data_i;
  logic                                done_v_o;
  logic [tag_width_lp-1:0]             done_tag_o;
  tag_pkg::done_t                      done_o;

  // reference model state
  logic [31:0]            lfsr_state;
  logic [num_tags_lp-1:0] busy_m;
  tag_pkg::req_payload_t  payload_m [num_tags_lp];
  exp_issue_t             issue_q [$];
  exp_done_t              done_q [$];
  logic                   req_hold;
  logic                   first_issue_seen;
  int                     errors;
  int                     issues_seen;
  int                     dones_seen;
  int                     full_cycles;
  int                     reuse_cycles;

  tag_tracker_top #(.num_tags_p(num_tags_lp)) u_tag_tracker_top (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_v_i    (req_v_i),
    .req_i      (req_i),
    .req_yumi_o (req_yumi_o),
    .issue_v_o  (issue_v_o),
    .issue_tag_o(issue_tag_o),
    .issue_o    (issue_o),
    .resp_v_i   (resp_v_i),
    .resp_tag_i (resp_tag_i),
    .resp_data_i(resp_data_i),
    .done_v_o   (done_v_o),
    .done_tag_o (done_tag_o),
    .done_o     (done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(clk_period_lp / 2) clk_i = ~clk_i;
    end
  end

  // galois form, taps for x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'hd000_0001;
    end
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
  endtask

  task automatic report_mismatch(input string name, input logic [63:0] exp_v,
                                 input logic [63:0] act_v);
    errors++;
    $display("FAILED %s expected %h actual %h", name, exp_v, act_v);
  endtask

  // registered outputs against what the model expected one cycle ago
  task automatic check_registered();
    exp_issue_t ei;
    exp_done_t  ed;
    if (issue_v_o === 1'b1) begin
      issues_seen++;
      if (!first_issue_seen) begin
        first_issue_seen = 1'b1;
        if (issue_tag_o !== '0) report_mismatch("first_tag", 64'd0, 64'(issue_tag_o));
      end
      if (issue_q.size() == 0) begin
        errors++;
        $display("issue_v_o went high without an accepted request");
      end else begin
        ei = issue_q.pop_front();
        if (issue_tag_o !== ei.tag) report_mismatch("issue_tag", 64'(ei.tag), 64'(issue_tag_o));
        if (issue_o.payload !== ei.payload) begin
          report_mismatch("issue_payload", 64'(ei.payload), 64'(issue_o.payload));
        end
      end
    end else if (issue_q.size() != 0) begin
      ei = issue_q.pop_front();
      errors++;
      $display("request accepted under tag %0d never showed up on issue_v_o", ei.tag);
    end
    if (done_v_o === 1'b1) begin
      dones_seen++;
      if (done_q.size() == 0) begin
        errors++;
        $display("done_v_o went high without a response");
      end else begin
        ed = done_q.pop_front();
        if (done_tag_o !== ed.tag) report_mismatch("done_tag", 64'(ed.tag), 64'(done_tag_o));
        if (done_o !== ed.result) report_mismatch("done_result", 64'(ed.result), 64'(done_o));
      end
    end else if (done_q.size() != 0) begin
      ed = done_q.pop_front();
      errors++;
      $display("response for tag %0d never showed up on done_v_o", ed.tag);
    end
  endtask

  task automatic drive_random(input int cyc);
    logic [31:0]             bits;
    logic                    slow_phase;
    logic                    found;
    logic [tag_width_lp-1:0] probe;
    slow_phase = ((cyc / 64) % 2) == 1;
    // a refused request is held unchanged
    if (!req_hold) begin
      take_bits(2, bits);
      req_v_i = (bits[1:0] != 2'b00);
      take_bits(2, bits);
      req_i.op = tag_pkg::tag_op_e'(bits[1:0]);
      take_bits(tag_pkg::payload_width, bits);
      req_i.addr = bits[tag_pkg::payload_width-1:0];
    end
    resp_v_i = 1'b0;
    take_bits(2, bits);
    if (busy_m != '0 && (slow_phase ? bits[1:0] == 2'b00 : bits[1:0] != 2'b00)) begin
      take_bits(tag_width_lp, bits);
      probe = bits[tag_width_lp-1:0];
      found = 1'b0;
      // walk up from a random start to the next outstanding tag
      for (int i = 0; i < num_tags_lp; i++) begin
        if (!found && busy_m[probe]) begin
          found = 1'b1;
          resp_tag_i = probe;
        end
        probe = probe + 1'b1;
      end
      resp_v_i = 1'b1;
      take_bits(tag_pkg::resp_data_width, bits);
      resp_data_i = bits[tag_pkg::resp_data_width-1:0];
    end
  endtask

  task automatic step_model();
    logic [num_tags_lp-1:0]  freed;
    logic [num_tags_lp-1:0]  cand;
    logic                    exp_yumi;
    logic [tag_width_lp-1:0] exp_tag;
    exp_issue_t              ei;
    exp_done_t               ed;
    freed = '0;
    if (resp_v_i) freed[resp_tag_i] = 1'b1;
    cand = ~busy_m | freed;
    exp_yumi = req_v_i && (cand != '0);
    exp_tag = '0;
    while (exp_tag != tag_width_lp'(num_tags_lp - 1) && !cand[exp_tag]) begin
      exp_tag = exp_tag + 1'b1;
    end
    if (req_yumi_o !== exp_yumi) report_mismatch("accept", 64'(exp_yumi), 64'(req_yumi_o));
    if (req_v_i && busy_m == '1 && !resp_v_i) full_cycles++;
    if (req_v_i && busy_m == '1 && resp_v_i) reuse_cycles++;
    // old payload is joined before a reuse overwrites it
    if (resp_v_i) begin
      ed.tag            = resp_tag_i;
      ed.result.payload = payload_m[resp_tag_i];
      ed.result.data    = resp_data_i;
      done_q.push_back(ed);
      busy_m[resp_tag_i] = 1'b0;
    end
    if (exp_yumi) begin
      ei.tag     = exp_tag;
      ei.payload = req_i;
      issue_q.push_back(ei);
      payload_m[exp_tag] = req_i;
      busy_m[exp_tag]    = 1'b1;
    end
    req_hold = req_v_i && !exp_yumi;
  endtask

  initial begin
    #((reset_cycles_lp + num_cycles_lp + 20) * clk_period_lp);
    $display("watchdog expired before the traffic sequence finished");
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    lfsr_state       = 32'he637_4d8c;
    reset_i          = 1'b1;
    req_v_i          = 1'b0;
    req_i            = '0;
    resp_v_i         = 1'b0;
    resp_tag_i       = '0;
    resp_data_i      = '0;
    busy_m           = '0;
    req_hold         = 1'b0;
    first_issue_seen = 1'b0;
    errors           = 0;
    issues_seen      = 0;
    dones_seen       = 0;
    full_cycles      = 0;
    reuse_cycles     = 0;
    repeat (reset_cycles_lp) begin
      @(posedge clk_i);
      #5;
      if ({req_yumi_o, issue_v_o, done_v_o} !== 3'b000) begin
        report_mismatch("reset_quiet", 64'd0, 64'({req_yumi_o, issue_v_o, done_v_o}));
      end
    end
    #5;
    reset_i = 1'b0;
    // check at +5, drive at +10, combinational check at +40
    for (int cyc = 0; cyc < num_cycles_lp; cyc++) begin
      @(posedge clk_i);
      #5;
      check_registered();
      #5;
      drive_random(cyc);
      #30;
      step_model();
    end
    @(posedge clk_i);
    #5;
    check_registered();
    #5;
    req_v_i  = 1'b0;
    resp_v_i = 1'b0;
    @(posedge clk_i);
    #5;
    check_registered();
    if (issue_q.size() != 0 || done_q.size() != 0) begin
      errors++;
      $display("model still holds expected outputs at the end of the run");
    end
    if (full_cycles == 0) begin
      errors++;
      $display("the pool never ran full while a request waited");
    end
    if (reuse_cycles == 0) begin
      errors++;
      $display("no freed tag was handed out again in the same cycle");
    end
    $display("errors=%0d issues=%0d completions=%0d full_pool_cycles=%0d reuse_cycles=%0d",
             errors, issues_seen, dones_seen, full_cycles, reuse_cycles);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
src/tag_pkg.sv
src/id_pool.sv
src/request_issuer.sv
src/tag_store.sv
src/completion_unit.sv
src/tag_tracker_top.sv
sim/tb_tag_tracker.sv

// File: Makefile
# Verilator build and run of the tag tracker testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_tag_tracker
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))
SIM_EXE := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_EXE): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_EXE)
	-./$(SIM_EXE) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "=== PASS ===" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
